/* Bender.yml */
package:
  name: i3c_target

sources:
  - files:
      - src/i3c_target_pkg.sv
      - src/tti_fifo.sv
      - src/rx_word_builder.sv
      - src/tx_byte_server.sv
      - src/flow_standby_i3c.sv
      - src/i3c_target_top.sv
  - target: test
    files:
      - bench/tb_i3c_target_top.sv

/* bench/tb_i3c_target_top.sv */
module tb_i3c_target_top;

  // Bytes over all transfers are writes of 0..13, CCC of 1+0, 1+5 and 1+11, reads of 12 words
  // plus 12 idle cycles, one invalid of 6 and one backpressure write of 48
  localparam int unsigned XFER_LEN = 91 + 19 + 48 + 12 + 6 + 48;
  localparam int unsigned CYCLE_LIMIT = XFER_LEN * 4 + 500;
  // Bytes that fill the RX queue and the word waiting at its input
  localparam int unsigned BP_LIMIT = (i3c_target_pkg::RX_Q_DEPTH + 1) * 4;

  logic clk_i;
  logic rst_ni;
  logic enable_i;
  logic transfer_start_i;
  logic transfer_stop_i;
  logic [1:0] transfer_type_i;
  logic rx_byte_valid_i;
  logic [7:0] rx_byte_i;
  logic rx_byte_ready_o;
  logic tx_byte_valid_o;
  logic [7:0] tx_byte_o;
  logic tx_byte_ready_i = 1'b0;
  logic rx_queue_rvalid_o;
  logic [31:0] rx_queue_rdata_o;
  logic rx_queue_rdesc_o;
  logic rx_queue_rready_i = 1'b0;
  logic tx_queue_wvalid_i;
  logic [31:0] tx_queue_wdata_i;
  logic tx_queue_wready_o;

  // Reference model holding the expected RX entries and TX bytes in order
  logic [32:0] rx_exp[1024];
  logic [9:0] rx_wr = '0;
  logic [9:0] rx_rd = '0;
  logic [7:0] tx_exp[1024];
  logic [9:0] tx_wr = '0;
  logic [9:0] tx_rd = '0;
  logic [32:0] rx_exp_head;
  logic [32:0] rx_act;
  i3c_target_pkg::tti_word_u tx_in;
  logic [3:0] rst_state;

  string test_name = "reset";
  logic [31:0] lfsr = 32'h864e_0eec;
  logic [1:0] rdy_bits = 2'b00;
  logic bp_hold = 1'b0;
  int unsigned bp_accepted = 0;
  int unsigned cycles = 0;

  i3c_target_top i3c_target_top_inst (.*);

  assign rx_exp_head = rx_exp[rx_rd];
  assign rx_act = {rx_queue_rdesc_o, rx_queue_rdata_o};
  assign tx_in = tx_queue_wdata_i;
  assign rst_state = {rx_byte_ready_o, tx_byte_valid_o, rx_queue_rvalid_o, tx_queue_wready_o};

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    $display("Simulation finished: FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  // Ready bits drawn mid-cycle and applied on the next rising edge
  always @(negedge clk_i) begin
    rdy_bits <= 2'(rand_bits(2));
  end

  always @(posedge clk_i) begin
    rx_queue_rready_i <= rst_ni && !bp_hold && rdy_bits[0];
    tx_byte_ready_i <= rst_ni && rdy_bits[1];
  end

  // Pops advance the model and TX queue writes fill it
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (rx_queue_rvalid_o && rx_queue_rready_i) begin
      rx_rd <= rx_rd + 10'd1;
    end
    if (tx_byte_valid_o && tx_byte_ready_i) begin
      tx_rd <= tx_rd + 10'd1;
    end
    if (tx_queue_wvalid_i && tx_queue_wready_o) begin
      // Least significant byte goes out first
      for (int k = 0; k < 4; k++) begin
        tx_exp[tx_wr + 10'(k)] <= tx_in.data[k];
      end
      tx_wr <= tx_wr + 10'd4;
    end
    if (!bp_hold) begin
      bp_accepted <= 0;
    end else if (rx_byte_valid_i && rx_byte_ready_o) begin
      bp_accepted <= bp_accepted + 1;
    end
    if (cycles >= CYCLE_LIMIT) begin
      report_failure("Timeout: the run did not complete within the cycle limit");
    end
  end

  a_reset_state: assert property (@(posedge clk_i) $rose(rst_ni) |-> (rst_state == 4'b0001))
    else report_mismatch("reset", 64'h1, 64'($sampled(rst_state)));
  a_rx_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rx_queue_rvalid_o && rx_queue_rready_i) |-> (rx_rd != rx_wr))
    else report_failure("RX queue returned a word that no transfer produced");
  a_rx_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rx_queue_rvalid_o && rx_queue_rready_i) |-> (rx_act == rx_exp_head))
    else report_mismatch(test_name, 64'($sampled(rx_exp_head)), 64'($sampled(rx_act)));
  a_tx_byte: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tx_byte_valid_o && tx_byte_ready_i) |-> (tx_byte_o == tx_exp[tx_rd]))
    else report_mismatch(test_name, 64'($sampled(tx_exp[tx_rd])), 64'($sampled(tx_byte_o)));
  // Nothing written to the TX queue means nothing on the bus
  a_tx_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tx_rd == tx_wr) |-> !tx_byte_valid_o)
    else report_mismatch(test_name, 64'h0, 64'($sampled(tx_byte_valid_o)));
  a_rx_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bp_hold |-> (bp_accepted <= BP_LIMIT))
    else report_mismatch(test_name, 64'(BP_LIMIT), 64'($sampled(bp_accepted)));

  task automatic expect_rx(input logic [32:0] w);
    rx_exp[rx_wr] = w;
    rx_wr = rx_wr + 10'd1;
  endtask

  task automatic start_xfer(input logic [1:0] t);
    transfer_start_i <= 1'b1;
    transfer_type_i <= t;
    @(posedge clk_i);
    transfer_start_i <= 1'b0;
  endtask

  task automatic stop_xfer();
    transfer_stop_i <= 1'b1;
    @(posedge clk_i);
    transfer_stop_i <= 0;
  endtask

  // Ready is looked at mid-cycle and the byte moves on the next edge
  task automatic send_byte(input logic [7:0] b);
    logic acc;
    int unsigned stall;
    stall = 0;
    rx_byte_valid_i <= 1'b1;
    rx_byte_i <= b;
    do begin
      @(negedge clk_i);
      acc = rx_byte_ready_o;
      if (!acc) begin
        stall++;
      end
      @(posedge clk_i);
      // Let the queue drain once the RX side has stalled against it
      if (bp_hold && stall >= 4) begin
        bp_hold <= 1'b0;
      end
    end while (!acc);
  endtask

  task automatic push_tx_word(input logic [31:0] w);
    logic acc;
    tx_queue_wvalid_i <= 1'b1;
    tx_queue_wdata_i <= w;
    do begin
      @(negedge clk_i);
      acc = tx_queue_wready_o;
      @(posedge clk_i);
    end while (!acc);
  endtask

  task automatic wait_rx_drained();
    @(negedge clk_i);
    while (rx_rd != rx_wr) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic wait_tx_sent();
    @(negedge clk_i);
    while (tx_rd != tx_wr) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  // Write, CCC or invalid transfer of n data bytes with a CCC code byte in front
  task automatic rx_xfer(input string name, input logic [1:0] t, input int unsigned n);
    i3c_target_pkg::tti_word_u w;
    logic [7:0] code;
    logic [7:0] b;
    logic keep;
    test_name = name;
    keep = (t != i3c_target_pkg::XFER_INVALID);
    w = '0;
    code = 8'h00;
    start_xfer(t);
    if (t == i3c_target_pkg::XFER_CCC) begin
      code = 8'(rand_bits(8));
      send_byte(code);
    end
    for (int unsigned i = 0; i < n; i++) begin
      b = 8'(rand_bits(8));
      w.data[i % 4] = b;
      if ((i % 4 == 3) && keep) begin
        expect_rx({1'b0, w});
        w = '0;
      end
      send_byte(b);
    end
    // Partial word keeps zeros in its unused lanes
    if ((n % 4 != 0) && keep) begin
      expect_rx({1'b0, w});
    end
    rx_byte_valid_i <= 1'b0;
    stop_xfer();
    w = '0;
    w.desc.err = !keep;
    w.desc.xfer_type = t;
    w.desc.ccc_code = code;
    w.desc.byte_cnt = keep ? i3c_target_pkg::BYTE_CNT_W'(n) : '0;
    expect_rx({1'b1, w});
    wait_rx_drained();
  endtask

  task automatic read_xfer(input string name, input int unsigned n);
    test_name = name;
    for (int unsigned i = 0; i < n; i++) begin
      push_tx_word(rand_bits(32));
    end
    tx_queue_wvalid_i <= 1'b0;
    start_xfer(i3c_target_pkg::XFER_READ);
    if (n == 0) begin
      repeat (12) @(posedge clk_i);
    end else begin
      wait_tx_sent();
    end
    stop_xfer();
  endtask

  initial begin
    rst_ni = 1'b0;
    enable_i = 1'b0;
    transfer_start_i = 1'b0;
    transfer_stop_i = 1'b0;
    transfer_type_i = 2'd0;
    rx_byte_valid_i = 1'b0;
    rx_byte_i = 8'h00;
    tx_queue_wvalid_i = 1'b0;
    tx_queue_wdata_i = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);
    enable_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    for (int unsigned n = 0; n <= 13; n++) begin
      rx_xfer("write", i3c_target_pkg::XFER_WRITE, n);
    end
    rx_xfer("ccc", i3c_target_pkg::XFER_CCC, 0);
    rx_xfer("ccc", i3c_target_pkg::XFER_CCC, 5);
    rx_xfer("ccc", i3c_target_pkg::XFER_CCC, 11);
    read_xfer("read", 3);
    read_xfer("read_empty", 0);
    read_xfer("read", 8);
    read_xfer("read", 1);
    rx_xfer("invalid", i3c_target_pkg::XFER_INVALID, 6);
    // Hold the RX queue reader off until the byte side stalls
    bp_hold <= 1'b1;
    @(posedge clk_i);
    rx_xfer("backpressure", i3c_target_pkg::XFER_WRITE, 48);
    repeat (4) @(posedge clk_i);
    if ((rx_rd != rx_wr) || (tx_rd != tx_wr)) begin
      report_failure("Expected words or bytes never came out of the queues");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* sources.f */
src/i3c_target_pkg.sv
src/tti_fifo.sv
src/rx_word_builder.sv
src/tx_byte_server.sv
src/flow_standby_i3c.sv
src/i3c_target_top.sv
bench/tb_i3c_target_top.sv

/* src/flow_standby_i3c.sv */
module flow_standby_i3c (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      enable_i,
  // Transfer framing from the bus engine
  input  logic                      transfer_start_i,
  input  logic                      transfer_stop_i,
  input  logic [1:0]                transfer_type_i,
  // Bytes received from the bus
  input  logic                      rx_byte_valid_i,
  input  logic [7:0]                rx_byte_i,
  output logic                      rx_byte_ready_o,
  // Bytes sent onto the bus
  output logic                      tx_byte_valid_o,
  output logic [7:0]                tx_byte_o,
  input  logic                      tx_byte_ready_i,
  // Towards the word builder
  output logic                      bld_byte_valid_o,
  output logic [7:0]                bld_byte_o,
  input  logic                      bld_byte_ready_i,
  output logic                      flush_req_o,
  output logic                      desc_valid_o,
  output i3c_target_pkg::tti_word_u desc_word_o,
  input  logic                      desc_ready_i,
  // From the TX byte server
  input  logic                      srv_byte_valid_i,
  input  logic [7:0]                srv_byte_i,
  output logic                      srv_byte_ready_o
);

  typedef enum logic [3:0] {
    Idle,
    TransferWait,
    TransferStart,
    TransferWrite,
    TransferRead,
    TransferCCC,
    TransferDrop,
    Flush,
    Describe
  } fsm_state_e;

  fsm_state_e state, state_next;
  fsm_state_e type_state, stop_state;
  logic [1:0] xfer_type;
  logic [7:0] ccc_code;
  // CCC code byte already taken
  logic ccc_seen;
  logic [i3c_target_pkg::BYTE_CNT_W-1:0] byte_cnt;
  logic fwd_en;

  // Data state for the captured type
  always_comb begin
    unique case (xfer_type)
      i3c_target_pkg::XFER_WRITE: type_state = TransferWrite;
      i3c_target_pkg::XFER_READ: type_state = TransferRead;
      i3c_target_pkg::XFER_CCC: type_state = TransferCCC;
      default: type_state = TransferDrop;
    endcase
  end

  // Reads end without a descriptor, dropped transfers skip the flush
  always_comb begin
    unique case (xfer_type)
      i3c_target_pkg::XFER_READ: stop_state = TransferWait;
      i3c_target_pkg::XFER_INVALID: stop_state = Describe;
      default: stop_state = Flush;
    endcase
  end

  always_comb begin
    state_next = state;
    unique case (state)
      Idle: begin
        if (enable_i) begin
          state_next = TransferWait;
        end
      end
      TransferWait: begin
        if (transfer_start_i) begin
          state_next = TransferStart;
        end else if (!enable_i) begin
          state_next = Idle;
        end
      end
      // Stop may follow start directly on an empty transfer
      TransferStart: begin
        state_next = transfer_stop_i ? stop_state : type_state;
      end
      TransferWrite, TransferRead, TransferCCC, TransferDrop: begin
        if (transfer_stop_i) begin
          state_next = stop_state;
        end
      end
      Flush: state_next = Describe;
      Describe: begin
        if (desc_ready_i) begin
          state_next = TransferWait;
        end
      end
      default: state_next = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state <= Idle;
      xfer_type <= i3c_target_pkg::XFER_WRITE;
      ccc_code <= '0;
      ccc_seen <= 1'b0;
      byte_cnt <= '0;
    end else begin
      state <= state_next;
      // Type is valid together with the start pulse
      if ((state == TransferWait) && transfer_start_i) begin
        xfer_type <= transfer_type_i;
        ccc_code <= '0;
        ccc_seen <= 1'b0;
        byte_cnt <= '0;
      end
      if ((state == TransferCCC) && !ccc_seen && rx_byte_valid_i) begin
        ccc_code <= rx_byte_i;
        ccc_seen <= 1'b1;
      end
      if (bld_byte_valid_o && bld_byte_ready_i) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  // Write data and CCC data after the code go to the builder
  assign fwd_en = (state == TransferWrite) || ((state == TransferCCC) && ccc_seen);
  assign bld_byte_valid_o = fwd_en && rx_byte_valid_i;
  assign bld_byte_o = rx_byte_i;
  // The code byte and dropped bytes are taken right away
  assign rx_byte_ready_o = fwd_en ? bld_byte_ready_i :
                           (state == TransferDrop) || ((state == TransferCCC) && !ccc_seen);

  // Server output reaches the bus only during a read
  assign tx_byte_valid_o = (state == TransferRead) && srv_byte_valid_i;
  assign tx_byte_o = srv_byte_i;
  assign srv_byte_ready_o = (state == TransferRead) && tx_byte_ready_i;

  assign flush_req_o = (state == Flush);
  assign desc_valid_o = (state == Describe);

  always_comb begin
    desc_word_o = '0;
    desc_word_o.desc.err = (xfer_type == i3c_target_pkg::XFER_INVALID);
    desc_word_o.desc.xfer_type = xfer_type;
    desc_word_o.desc.ccc_code = ccc_code;
    desc_word_o.desc.byte_cnt = byte_cnt;
  end

  // The bus engine only opens a transfer once the previous one is closed
  a_start_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    transfer_start_i |-> (state == TransferWait));

endmodule

/* src/i3c_target_pkg.sv */
package i3c_target_pkg;

  // Queue word width as seen by the TTI queues
  localparam int unsigned TTI_WORD_W = 32;
  // RX queue entry carries one extra bit marking a descriptor
  localparam int unsigned RX_Q_W = TTI_WORD_W + 1;

  // Queue depths in words
  localparam int unsigned RX_Q_DEPTH = 8;
  localparam int unsigned TX_Q_DEPTH = 8;

  // Per-transfer byte counter width
  localparam int unsigned BYTE_CNT_W = 12;

  // Transfer type codes from the bus engine
  localparam logic [1:0] XFER_WRITE = 2'd0;
  localparam logic [1:0] XFER_READ = 2'd1;
  localparam logic [1:0] XFER_CCC = 2'd2;
  localparam logic [1:0] XFER_INVALID = 2'd3;

  // Descriptor appended after the data of each transfer
  typedef struct packed {
    // Always zero
    logic [8:0] reserved;
    // Set when the transfer type was invalid
    logic err;
    logic [1:0] xfer_type;
    // Zero unless the transfer was a CCC
    logic [7:0] ccc_code;
    // Data bytes only, the CCC code byte is not counted
    logic [BYTE_CNT_W-1:0] byte_cnt;
  } rx_desc_t;

  // One queue word, either four bus bytes or a descriptor
  typedef union packed {
    // Byte 0 is the first byte seen on the bus
    logic [3:0][7:0] data;
    rx_desc_t desc;
  } tti_word_u;

endpackage

/* src/i3c_target_top.sv */
module i3c_target_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  enable_i,
  input  logic                                  transfer_start_i,
  input  logic                                  transfer_stop_i,
  input  logic [1:0]                            transfer_type_i,
  // Bus RX bytes
  input  logic                                  rx_byte_valid_i,
  input  logic [7:0]                            rx_byte_i,
  output logic                                  rx_byte_ready_o,
  // Bus TX bytes
  output logic                                  tx_byte_valid_o,
  output logic [7:0]                            tx_byte_o,
  input  logic                                  tx_byte_ready_i,
  // RX queue read port
  output logic                                  rx_queue_rvalid_o,
  output logic [i3c_target_pkg::TTI_WORD_W-1:0] rx_queue_rdata_o,
  output logic                                  rx_queue_rdesc_o,
  input  logic                                  rx_queue_rready_i,
  // TX queue write port
  input  logic                                  tx_queue_wvalid_i,
  input  logic [i3c_target_pkg::TTI_WORD_W-1:0] tx_queue_wdata_i,
  output logic                                  tx_queue_wready_o
);

  // Controller to builder
  logic bld_byte_valid;
  logic [7:0] bld_byte;
  logic bld_byte_ready;
  logic flush_req;
  logic desc_valid;
  i3c_target_pkg::tti_word_u desc_word;
  logic desc_ready;

  // Builder to RX queue
  logic rx_q_wvalid;
  logic [i3c_target_pkg::RX_Q_W-1:0] rx_q_wdata;
  logic rx_q_wready;
  logic [i3c_target_pkg::RX_Q_W-1:0] rx_q_rdata;

  // TX queue to server, server to controller
  logic tx_q_rvalid;
  logic [i3c_target_pkg::TTI_WORD_W-1:0] tx_q_rdata;
  logic tx_q_rready;
  logic srv_byte_valid;
  logic [7:0] srv_byte;
  logic srv_byte_ready;

  // Top bit of an RX entry marks a descriptor
  assign rx_queue_rdata_o = rx_q_rdata[i3c_target_pkg::TTI_WORD_W-1:0];
  assign rx_queue_rdesc_o = rx_q_rdata[i3c_target_pkg::RX_Q_W-1];

  flow_standby_i3c flow_standby_i3c_inst (
    .clk_i, .rst_ni, .enable_i,
    .transfer_start_i, .transfer_stop_i, .transfer_type_i,
    .rx_byte_valid_i, .rx_byte_i, .rx_byte_ready_o,
    .tx_byte_valid_o, .tx_byte_o, .tx_byte_ready_i,
    .bld_byte_valid_o(bld_byte_valid), .bld_byte_o(bld_byte),
    .bld_byte_ready_i(bld_byte_ready), .flush_req_o(flush_req),
    .desc_valid_o(desc_valid), .desc_word_o(desc_word), .desc_ready_i(desc_ready),
    .srv_byte_valid_i(srv_byte_valid), .srv_byte_i(srv_byte),
    .srv_byte_ready_o(srv_byte_ready)
  );

  rx_word_builder rx_word_builder_inst (
    .clk_i, .rst_ni,
    .byte_valid_i(bld_byte_valid), .byte_i(bld_byte), .byte_ready_o(bld_byte_ready),
    .flush_req_i(flush_req), .desc_valid_i(desc_valid),
    .desc_word_i(desc_word), .desc_ready_o(desc_ready),
    .q_wvalid_o(rx_q_wvalid), .q_wdata_o(rx_q_wdata), .q_wready_i(rx_q_wready)
  );

  tti_fifo #(
    .DataWidth(i3c_target_pkg::RX_Q_W),
    .Depth(i3c_target_pkg::RX_Q_DEPTH)
  ) rx_fifo_inst (
    .clk_i, .rst_ni,
    .wvalid_i(rx_q_wvalid), .wdata_i(rx_q_wdata), .wready_o(rx_q_wready),
    .rvalid_o(rx_queue_rvalid_o), .rdata_o(rx_q_rdata), .rready_i(rx_queue_rready_i)
  );

  tti_fifo #(
    .DataWidth(i3c_target_pkg::TTI_WORD_W),
    .Depth(i3c_target_pkg::TX_Q_DEPTH)
  ) tx_fifo_inst (
    .clk_i, .rst_ni,
    .wvalid_i(tx_queue_wvalid_i), .wdata_i(tx_queue_wdata_i), .wready_o(tx_queue_wready_o),
    .rvalid_o(tx_q_rvalid), .rdata_o(tx_q_rdata), .rready_i(tx_q_rready)
  );

  tx_byte_server tx_byte_server_inst (
    .clk_i, .rst_ni,
    .q_rvalid_i(tx_q_rvalid), .q_rdata_i(tx_q_rdata), .q_rready_o(tx_q_rready),
    .byte_valid_o(srv_byte_valid), .byte_o(srv_byte), .byte_ready_i(srv_byte_ready)
  );

endmodule

/* src/rx_word_builder.sv */
module rx_word_builder (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Data bytes from the flow controller
  input  logic                                byte_valid_i,
  input  logic [7:0]                          byte_i,
  output logic                                byte_ready_o,
  // End of data and descriptor
  input  logic                                flush_req_i,
  input  logic                                desc_valid_i,
  input  i3c_target_pkg::tti_word_u           desc_word_i,
  output logic                                desc_ready_o,
  // Write port of the RX queue
  output logic                                q_wvalid_o,
  output logic [i3c_target_pkg::RX_Q_W-1:0]   q_wdata_o,
  input  logic                                q_wready_i
);

  // Next free byte lane in the staging word
  logic [1:0] lane;
  i3c_target_pkg::tti_word_u stage;
  i3c_target_pkg::tti_word_u partial;
  // Partial word still to be written
  logic flush_pend;
  logic slot_free;
  logic byte_acc;
  logic push_word;
  logic push_flush;
  logic push_desc;

  // Output register is free or empties this cycle
  assign slot_free = !q_wvalid_o || q_wready_i;
  assign byte_ready_o = slot_free && !flush_pend;
  // Descriptor only once every data byte has left
  assign desc_ready_o = slot_free && !flush_pend && (lane == 2'd0);

  assign byte_acc = byte_valid_i && byte_ready_o;
  assign push_word = byte_acc && (lane == 2'd3);
  assign push_flush = flush_pend && slot_free;
  assign push_desc = desc_valid_i && desc_ready_o;

  // Unused lanes of a partial word read as zero
  always_comb begin
    partial = stage;
    for (int i = 0; i < 4; i++) begin
      if (i >= lane) begin
        partial.data[i] = 8'h00;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q_wvalid_o <= 1'b0;
      lane <= '0;
      flush_pend <= 1'b0;
    end else begin
      if (q_wready_i) begin
        q_wvalid_o <= 1'b0;
      end
      if (push_word || push_flush || push_desc) begin
        q_wvalid_o <= 1'b1;
      end
      // Lane wraps to zero after the fourth byte
      if (byte_acc) begin
        lane <= lane + 2'd1;
      end else if (push_flush) begin
        lane <= '0;
      end
      // An empty staging word needs no flush
      if (flush_req_i && (lane != 2'd0)) begin
        flush_pend <= 1'b1;
      end else if (push_flush) begin
        flush_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_acc) begin
      stage.data[lane] <= byte_i;
    end
    // Marker bit is the top bit of the queue entry
    if (push_word) begin
      q_wdata_o <= {1'b0, byte_i, stage.data[2:0]};
    end else if (push_flush) begin
      q_wdata_o <= {1'b0, partial};
    end else if (push_desc) begin
      q_wdata_o <= {1'b1, desc_word_i};
    end
  end

  // The controller stops forwarding bytes before it flushes
  a_no_byte_on_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_req_i |-> !byte_acc);

endmodule

/* src/tti_fifo.sv */
module tti_fifo #(
  parameter int unsigned DataWidth = i3c_target_pkg::TTI_WORD_W,
  parameter int unsigned Depth = i3c_target_pkg::RX_Q_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Write side
  input  logic                 wvalid_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 wready_o,
  // Read side where the first word falls through
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  input  logic                 rready_i
);

  localparam int unsigned PtrW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [DataWidth-1:0] mem[Depth];
  logic [PtrW-1:0] wptr;
  logic [PtrW-1:0] rptr;
  logic [CntW-1:0] count;
  logic push;
  logic pop;

  // Head of the queue is always on the read port
  assign rvalid_o = (count != '0);
  assign rdata_o = mem[rptr];
  // A full queue still takes a word when the head leaves in the same cycle
  assign wready_o = (count != CntW'(Depth)) || rready_i;

  assign push = wvalid_i && wready_o;
  assign pop = rvalid_o && rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr <= '0;
      rptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= (wptr == PtrW'(Depth - 1)) ? '0 : wptr + 1'b1;
      end
      if (pop) begin
        rptr <= (rptr == PtrW'(Depth - 1)) ? '0 : rptr + 1'b1;
      end
      // Occupancy moves by at most one
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage written only on an accepted push
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr] <= wdata_i;
    end
  end

  // A full queue has its write pointer wrapped back onto the head
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count == CntW'(Depth)) |-> (wptr == rptr));
  // An empty queue has no word left between the pointers
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count == '0) |-> (wptr == rptr));

endmodule

/* src/tx_byte_server.sv */
module tx_byte_server (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Read port of the TX queue
  input  logic                                  q_rvalid_i,
  input  logic [i3c_target_pkg::TTI_WORD_W-1:0] q_rdata_i,
  output logic                                  q_rready_o,
  // Bytes towards the bus
  output logic                                  byte_valid_o,
  output logic [7:0]                            byte_o,
  input  logic                                  byte_ready_i
);

  logic [3:0][7:0] word;
  // Next byte to send, zero is the least significant
  logic [1:0] idx;
  // Word holds bytes still to send
  logic held;

  // Fetch only when nothing is left
  assign q_rready_o = !held;
  assign byte_valid_o = held;
  assign byte_o = word[idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held <= 1'b0;
      idx <= '0;
    end else begin
      if (q_rvalid_i && q_rready_o) begin
        held <= 1'b1;
        idx <= '0;
      end else if (byte_valid_o && byte_ready_i) begin
        idx <= idx + 2'd1;
        // Last byte of the word
        if (idx == 2'd3) begin
          held <= 1'b0;
        end
      end
    end
  end

  // Kept across transfers until every byte is sent
  always_ff @(posedge clk_i) begin
    if (q_rvalid_i && q_rready_o) begin
      word <= q_rdata_i;
    end
  end

endmodule
